// ==== logic/ntt_field_pkg.sv ====
package ntt_field_pkg;

    // transform size
    localparam int N            = 16;
    localparam int LOG_N        = $clog2(N);   // 4 stages, 4-bit index

    // coefficient word
    localparam int COEF_W       = 7;           // holds 0..96

    // butterfly pipeline depth, data in to write out
    localparam int BFLY_LATENCY = 3;

    // one coefficient mod Q
    typedef logic [COEF_W-1:0] coef_t;

    // coefficient index into the 16-word memory
    typedef logic [LOG_N-1:0] addr_t;

    // twiddle exponent, 0..N/2-1
    typedef logic [LOG_N-2:0] tw_addr_t;

    // prime field
    localparam coef_t Q    = 7'd97;

    // 8^16 = 1 mod 97 and 8^8 = 96, so primitive 16th root
    localparam coef_t ROOT = 7'd8;

endpackage

// ==== logic/ntt_ctrl_pkg.sv ====
package ntt_ctrl_pkg;

    // top level phases of one transform
    typedef enum logic [1:0] {
        IDLE_LOAD = 2'd0,   // accepting coefficients
        COMPUTE   = 2'd1,   // issuing 8 butterflies
        DRAIN     = 2'd2,   // waiting out the pipeline
        OUTPUT    = 2'd3    // streaming results
    } phase_t;

    // one butterfly, issued by the sequencer
    typedef struct packed {
        logic                    valid;
        ntt_field_pkg::addr_t    addr_a;    // top input, gets the sum
        ntt_field_pkg::addr_t    addr_b;    // bottom input, gets the twiddled diff
        ntt_field_pkg::tw_addr_t tw_addr;
    } bfly_req_t;

    // a single memory write port
    typedef struct packed {
        logic                 en;
        ntt_field_pkg::addr_t addr;
        ntt_field_pkg::coef_t data;
    } mem_write_t;

    // sequencer status back to the phase FSM
    typedef struct packed {
        logic stage_done;       // one cycle, last drain cycle
        logic all_stages_done;  // same cycle, but only for stage 3
        logic count_wrap;       // index counter at its last value
    } seq_status_t;

endpackage

// ==== logic/ntt_phase_fsm.sv ====
`timescale 1ns/1ps

module ntt_phase_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  ntt_ctrl_pkg::seq_status_t seq_status,
    input  logic                      out_done,
    output ntt_ctrl_pkg::phase_t      phase,
    output logic                      in_ready
);

    ntt_ctrl_pkg::phase_t phase_nxt;

    // only the load phase takes input
    assign in_ready = (phase == ntt_ctrl_pkg::IDLE_LOAD);

    always_comb begin
        phase_nxt = phase;   // hold by default
        case (phase)
            ntt_ctrl_pkg::IDLE_LOAD: begin
                // 16th word accepted this cycle
                if (in_valid && seq_status.count_wrap) begin
                    phase_nxt = ntt_ctrl_pkg::COMPUTE;
                end
            end
            ntt_ctrl_pkg::COMPUTE: begin
                if (seq_status.count_wrap) begin   // 8th butterfly out
                    phase_nxt = ntt_ctrl_pkg::DRAIN;
                end
            end
            ntt_ctrl_pkg::DRAIN: begin
                if (seq_status.stage_done) begin
                    // last stage goes straight to output
                    phase_nxt = seq_status.all_stages_done ? ntt_ctrl_pkg::OUTPUT
                                                           : ntt_ctrl_pkg::COMPUTE;
                end
            end
            ntt_ctrl_pkg::OUTPUT: begin
                if (out_done) begin
                    phase_nxt = ntt_ctrl_pkg::IDLE_LOAD;
                end
            end
            default: phase_nxt = ntt_ctrl_pkg::IDLE_LOAD;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= ntt_ctrl_pkg::IDLE_LOAD;
        end else begin
            phase <= phase_nxt;
        end
    end

    // phase register never picks up X from status or handshake inputs
    a_phase_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(phase));

endmodule

// ==== logic/butterfly_sequencer.sv ====
`timescale 1ns/1ps

module butterfly_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  ntt_ctrl_pkg::phase_t      phase,
    input  logic                      load_take,
    input  logic                      read_take,
    output ntt_ctrl_pkg::bfly_req_t   req,
    output ntt_field_pkg::addr_t      out_addr,
    output ntt_ctrl_pkg::seq_status_t seq_status
);

    typedef logic [$clog2(ntt_field_pkg::LOG_N)-1:0]          stage_t;
    typedef logic [$clog2(ntt_field_pkg::BFLY_LATENCY+1)-1:0] drain_t;

    ntt_field_pkg::addr_t cnt;         // load index, butterfly index, output index
    stage_t               stage;
    drain_t               drain_cnt;   // counts down through the drain
    logic                 in_compute;

    assign in_compute = (phase == ntt_ctrl_pkg::COMPUTE);

    // wrap point is 7 while issuing butterflies, 15 otherwise
    assign seq_status.count_wrap = in_compute
        ? (cnt == ntt_field_pkg::addr_t'(ntt_field_pkg::N / 2 - 1))
        : (cnt == ntt_field_pkg::addr_t'(ntt_field_pkg::N - 1));
    assign seq_status.stage_done = (phase == ntt_ctrl_pkg::DRAIN) && (drain_cnt == '0);
    assign seq_status.all_stages_done = seq_status.stage_done
        && (stage == stage_t'(ntt_field_pkg::LOG_N - 1));

    assign out_addr = cnt;   // load write address

    always_comb begin
        ntt_field_pkg::addr_t half;
        ntt_field_pkg::addr_t lo;
        ntt_field_pkg::addr_t base;
        half = ntt_field_pkg::addr_t'(ntt_field_pkg::N / 2) >> stage;   // 8 >> s
        lo   = cnt & (half - 1'b1);                                      // j mod h
        base = ((cnt & ~(half - 1'b1)) << 1) | lo;                       // (j/h)*2h + j mod h
        if (in_compute) begin
            req.valid   = 1'b1;
            req.addr_a  = base;
            req.addr_b  = base + half;
            req.tw_addr = ntt_field_pkg::tw_addr_t'(lo << stage);        // (j mod h) * 2^s
        end else begin
            // output reads ride on port a, no butterfly
            req.valid   = 1'b0;
            req.addr_a  = cnt;
            req.addr_b  = cnt;
            req.tw_addr = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt       <= '0;
            stage     <= '0;
            drain_cnt <= '0;
        end else begin
            case (phase)
                ntt_ctrl_pkg::IDLE_LOAD: if (load_take) cnt <= cnt + 1'b1;   // wraps to 0
                ntt_ctrl_pkg::COMPUTE: begin
                    cnt       <= seq_status.count_wrap ? '0 : cnt + 1'b1;
                    drain_cnt <= drain_t'(ntt_field_pkg::BFLY_LATENCY);      // 4 drain cycles
                end
                ntt_ctrl_pkg::DRAIN: begin
                    drain_cnt <= drain_cnt - 1'b1;
                    if (seq_status.stage_done) stage <= stage + 1'b1;        // 3 wraps to 0
                end
                default: if (read_take) cnt <= cnt + 1'b1;                   // output index
            endcase
        end
    end

    // pair is ordered and in range for every stage
    a_pair_order: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> (req.addr_b > req.addr_a));

endmodule

// ==== logic/coef_memory.sv ====
`timescale 1ns/1ps

module coef_memory (
    input  logic                     clk,
    input  logic                     reset,
    input  ntt_field_pkg::addr_t     rd_a,
    input  ntt_field_pkg::addr_t     rd_b,
    input  ntt_ctrl_pkg::mem_write_t wr_a,
    input  ntt_ctrl_pkg::mem_write_t wr_b,
    output ntt_field_pkg::coef_t     q_a,
    output ntt_field_pkg::coef_t     q_b
);

    ntt_field_pkg::coef_t mem [ntt_field_pkg::N];

    // two write ports, in-place butterfly results
    always_ff @(posedge clk) begin
        if (wr_a.en) mem[wr_a.addr] <= wr_a.data;   // load data or sum
        if (wr_b.en) mem[wr_b.addr] <= wr_b.data;   // twiddled diff
    end

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_a <= '0;
            q_b <= '0;
        end else begin
            q_a <= mem[rd_a];
            q_b <= mem[rd_b];
        end
    end

    // load path and butterfly pipeline never collide on one word
    a_no_write_clash: assert property (@(posedge clk) disable iff (reset)
        (wr_a.en && wr_b.en) |-> (wr_a.addr != wr_b.addr));

endmodule

// ==== logic/twiddle_rom.sv ====
`timescale 1ns/1ps

module twiddle_rom (
    input  logic                    clk,
    input  ntt_field_pkg::tw_addr_t tw_addr,
    output ntt_field_pkg::coef_t    tw
);

    ntt_field_pkg::coef_t rom [ntt_field_pkg::N / 2];

    // ROOT^e mod Q by repeated multiply
    function automatic ntt_field_pkg::coef_t pow_root(int unsigned e);
        int unsigned acc;
        acc = 1;
        for (int unsigned i = 0; i < e; i++) begin
            acc = (acc * 32'(ntt_field_pkg::ROOT)) % 32'(ntt_field_pkg::Q);
        end
        return ntt_field_pkg::coef_t'(acc);
    endfunction

    for (genvar k = 0; k < ntt_field_pkg::N / 2; k++) begin : g_tw
        assign rom[k] = pow_root(k);   // 1, 8, 64, 27, ...
    end

    // same one-cycle latency as the coefficient reads
    always_ff @(posedge clk) begin
        tw <= rom[tw_addr];
    end

endmodule

// ==== logic/butterfly_unit.sv ====
`timescale 1ns/1ps

module butterfly_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  ntt_ctrl_pkg::bfly_req_t  req,
    input  ntt_field_pkg::coef_t     a,
    input  ntt_field_pkg::coef_t     b,
    input  ntt_field_pkg::coef_t     tw,
    output ntt_ctrl_pkg::mem_write_t wr_a,
    output ntt_ctrl_pkg::mem_write_t wr_b
);

    typedef logic [2*ntt_field_pkg::COEF_W-1:0] prod_t;   // full diff * tw

    ntt_ctrl_pkg::bfly_req_t req_d;    // lines up with read data
    ntt_ctrl_pkg::bfly_req_t s1_req;
    ntt_ctrl_pkg::bfly_req_t s2_req;
    ntt_field_pkg::coef_t    sum_mod;
    ntt_field_pkg::coef_t    diff_mod;
    ntt_field_pkg::coef_t    s1_sum;
    ntt_field_pkg::coef_t    s1_diff;
    ntt_field_pkg::coef_t    s1_tw;
    ntt_field_pkg::coef_t    s2_sum;
    prod_t                   s2_prod;

    // stage 1 arithmetic, both outputs in 0..Q-1
    always_comb begin
        logic [ntt_field_pkg::COEF_W:0] sum_full;
        sum_full = {1'b0, a} + {1'b0, b};
        sum_mod  = (sum_full >= {1'b0, ntt_field_pkg::Q})
                 ? ntt_field_pkg::coef_t'(sum_full - {1'b0, ntt_field_pkg::Q})
                 : ntt_field_pkg::coef_t'(sum_full);
        diff_mod = (a >= b) ? a - b : a + (ntt_field_pkg::Q - b);   // borrow adds Q back
    end

    // addresses travel with the data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_d  <= '0;
            s1_req <= '0;
            s2_req <= '0;
        end else begin
            req_d  <= req;
            s1_req <= req_d;
            s2_req <= s1_req;
        end
    end

    always_ff @(posedge clk) begin
        s1_sum  <= sum_mod;
        s1_diff <= diff_mod;
        s1_tw   <= tw;
        s2_sum  <= s1_sum;                            // sum just waits a stage
        s2_prod <= prod_t'(s1_diff) * prod_t'(s1_tw); // stage 2 multiply
    end

    // stage 3, plain remainder then write back
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_a <= '0;
            wr_b <= '0;
        end else begin
            wr_a <= '{en: s2_req.valid, addr: s2_req.addr_a, data: s2_sum};
            wr_b <= '{en: s2_req.valid, addr: s2_req.addr_b,
                      data: ntt_field_pkg::coef_t'(s2_prod % prod_t'(ntt_field_pkg::Q))};
        end
    end

endmodule

// ==== logic/result_streamer.sv ====
`timescale 1ns/1ps

module result_streamer (
    input  logic                 clk,
    input  logic                 reset,
    input  ntt_ctrl_pkg::phase_t phase,
    input  ntt_field_pkg::coef_t rd_data,
    input  logic                 out_ready,
    output logic                 read_take,
    output logic                 out_valid,
    output ntt_field_pkg::coef_t out_data,
    output logic                 out_last,
    output logic                 out_done
);

    typedef logic [ntt_field_pkg::LOG_N:0] issue_cnt_t;   // 0..16

    logic                 pending;    // read data sits on rd_data now
    logic                 full;       // stalled word parked in hold_data
    ntt_field_pkg::coef_t hold_data;
    issue_cnt_t           rd_cnt;     // reads issued this transform
    ntt_field_pkg::addr_t out_cnt;    // words transferred
    logic                 xfer;
    logic                 in_output;

    assign in_output = (phase == ntt_ctrl_pkg::OUTPUT);
    assign out_valid = pending | full;
    assign out_data  = full ? hold_data : rd_data;
    assign xfer      = out_valid & out_ready;
    assign out_last  = out_valid && (out_cnt == ntt_field_pkg::addr_t'(ntt_field_pkg::N - 1));

    // next read only when the slot frees up this cycle
    assign read_take = in_output && (rd_cnt != issue_cnt_t'(ntt_field_pkg::N))
                    && (!out_valid || out_ready);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending  <= 1'b0;
            full     <= 1'b0;
            rd_cnt   <= '0;
            out_cnt  <= '0;
            out_done <= 1'b0;
        end else begin
            pending  <= read_take;
            out_done <= xfer && out_last;   // one cycle after the 16th word
            if (pending && !out_ready) full <= 1'b1;
            else if (xfer) full <= 1'b0;
            if (!in_output) rd_cnt <= '0;
            else if (read_take) rd_cnt <= rd_cnt + 1'b1;
            if (!in_output) out_cnt <= '0;
            else if (xfer) out_cnt <= out_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pending && !out_ready) hold_data <= rd_data;   // memory moves on next cycle
    end

    // stalled word stays put until taken
    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)));

endmodule

// ==== logic/ntt_core.sv ====
`timescale 1ns/1ps

module ntt_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  ntt_field_pkg::coef_t in_data,
    output logic                 in_ready,
    output logic                 out_valid,
    input  logic                 out_ready,
    output ntt_field_pkg::coef_t out_data,
    output logic                 out_last
);

    ntt_ctrl_pkg::phase_t      phase;
    ntt_ctrl_pkg::seq_status_t seq_status;
    ntt_ctrl_pkg::bfly_req_t   req;
    ntt_field_pkg::addr_t      out_addr;     // load write index
    ntt_ctrl_pkg::mem_write_t  load_wr;
    ntt_ctrl_pkg::mem_write_t  bfly_wr_a;
    ntt_ctrl_pkg::mem_write_t  bfly_wr_b;
    ntt_ctrl_pkg::mem_write_t  mem_wr_a;
    ntt_field_pkg::coef_t      q_a;
    ntt_field_pkg::coef_t      q_b;
    ntt_field_pkg::coef_t      tw;
    logic                      read_take;
    logic                      out_done;

    // port a carries the load stream while loading, butterfly sums otherwise
    assign load_wr  = '{en: in_valid & in_ready, addr: out_addr, data: in_data};
    assign mem_wr_a = in_ready ? load_wr : bfly_wr_a;

    ntt_phase_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .seq_status (seq_status),
        .out_done   (out_done),
        .phase      (phase),
        .in_ready   (in_ready)
    );

    butterfly_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .phase      (phase),
        .load_take  (in_valid),     // qualified by phase inside
        .read_take  (read_take),
        .req        (req),
        .out_addr   (out_addr),
        .seq_status (seq_status)
    );

    coef_memory u_mem (
        .clk   (clk),
        .reset (reset),
        .rd_a  (req.addr_a),        // output index outside compute
        .rd_b  (req.addr_b),
        .wr_a  (mem_wr_a),
        .wr_b  (bfly_wr_b),
        .q_a   (q_a),
        .q_b   (q_b)
    );

    twiddle_rom u_rom (
        .clk     (clk),
        .tw_addr (req.tw_addr),
        .tw      (tw)
    );

    butterfly_unit u_bfly (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .a     (q_a),
        .b     (q_b),
        .tw    (tw),
        .wr_a  (bfly_wr_a),
        .wr_b  (bfly_wr_b)
    );

    result_streamer u_out (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .rd_data   (q_a),
        .out_ready (out_ready),
        .read_take (read_take),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_done  (out_done)
    );

endmodule

// ==== verification/ntt_core_tb.sv ====
`timescale 1ns/1ps

module ntt_core_tb;

    localparam int N          = ntt_field_pkg::N;
    localparam int LOG_N      = ntt_field_pkg::LOG_N;
    localparam int NUM_RUNS   = 8;
    localparam int MODEL_Q    = 97;    // field modulus for the model
    localparam int MODEL_ROOT = 8;     // primitive 16th root of unity
    localparam int DRIVE_DLY  = 2;     // ns after the rising edge
    localparam int WAIT_LIMIT = 300;   // cycles per wait loop

    // vector kinds
    localparam logic [2:0] VEC_IMPULSE = 3'd0;
    localparam logic [2:0] VEC_ONES    = 3'd1;
    localparam logic [2:0] VEC_RAMP    = 3'd2;
    localparam logic [2:0] VEC_MAX     = 3'd3;
    localparam logic [2:0] VEC_RANDOM  = 3'd4;

    // out_ready patterns
    localparam logic [1:0] RDY_ALWAYS = 2'd0;
    localparam logic [1:0] RDY_RANDOM = 2'd1;
    localparam logic [1:0] RDY_TOGGLE = 2'd2;
    localparam logic [1:0] RDY_SPARSE = 2'd3;   // mostly stalled

    typedef struct packed {
        logic [2:0] kind;
        logic [1:0] ready_mode;
        logic       noise;   // in_valid pulses while busy
        logic [3:0] gap;     // idle cycles before load, 0 is back to back
    } run_cfg_t;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    ntt_field_pkg::coef_t in_data;
    logic                 in_ready;
    logic                 out_valid;
    logic                 out_ready;
    ntt_field_pkg::coef_t out_data;
    logic                 out_last;

    run_cfg_t             run_table [NUM_RUNS];
    ntt_field_pkg::coef_t stim_coef [NUM_RUNS][N];
    ntt_field_pkg::coef_t exp_coef  [NUM_RUNS][N];   // already in bit-reversed order

    ntt_core dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: gave up waiting for %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "wait loop expired");
    endtask

    // inputs change a little after the edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    function automatic int mod_pow(input int base, input int e);
        int acc;
        acc = 1;
        for (int i = 0; i < e; i++) begin
            acc = (acc * base) % MODEL_Q;
        end
        return acc;
    endfunction

    function automatic int bit_reverse(input int v);
        int r;
        r = 0;
        for (int b = 0; b < LOG_N; b++) begin
            r = (r << 1) | ((v >> b) & 1);
        end
        return r;
    endfunction

    // direct O(N^2) transform, then scrambled order
    task automatic build_expected(input int r);
        int spectrum [N];
        int acc;
        for (int k = 0; k < N; k++) begin
            acc = 0;
            for (int i = 0; i < N; i++) begin
                acc = (acc + int'(stim_coef[r][i]) * mod_pow(MODEL_ROOT, (i * k) % N))
                    % MODEL_Q;
            end
            spectrum[k] = acc;
        end
        for (int j = 0; j < N; j++) begin
            exp_coef[r][j] = ntt_field_pkg::coef_t'(spectrum[bit_reverse(j)]);
        end
    endtask

    task automatic fill_tables();
        run_table[0] = '{kind: VEC_IMPULSE, ready_mode: RDY_ALWAYS, noise: 1'b0, gap: 4'd3};
        run_table[1] = '{kind: VEC_ONES,    ready_mode: RDY_ALWAYS, noise: 1'b0, gap: 4'd1};
        run_table[2] = '{kind: VEC_RAMP,    ready_mode: RDY_TOGGLE, noise: 1'b0, gap: 4'd2};
        run_table[3] = '{kind: VEC_MAX,     ready_mode: RDY_RANDOM, noise: 1'b1, gap: 4'd0};
        run_table[4] = '{kind: VEC_RANDOM,  ready_mode: RDY_RANDOM, noise: 1'b1, gap: 4'd5};
        run_table[5] = '{kind: VEC_RANDOM,  ready_mode: RDY_SPARSE, noise: 1'b0, gap: 4'd0};
        run_table[6] = '{kind: VEC_RAMP,    ready_mode: RDY_ALWAYS, noise: 1'b1, gap: 4'd0};
        run_table[7] = '{kind: VEC_RANDOM,  ready_mode: RDY_SPARSE, noise: 1'b1, gap: 4'd0};
        for (int r = 0; r < NUM_RUNS; r++) begin
            for (int i = 0; i < N; i++) begin
                case (run_table[r].kind)
                    VEC_IMPULSE: stim_coef[r][i] = (i == 0) ? 7'd1 : 7'd0;
                    VEC_ONES:    stim_coef[r][i] = 7'd1;
                    VEC_RAMP:    stim_coef[r][i] = ntt_field_pkg::coef_t'(i);
                    VEC_MAX:     stim_coef[r][i] = 7'd96;   // all q-1
                    default:     stim_coef[r][i] = ntt_field_pkg::coef_t'($urandom_range(96, 0));
                endcase
            end
            build_expected(r);
        end
    endtask

    function automatic logic ready_for_mode(input logic [1:0] mode, input int cycle);
        case (mode)
            RDY_ALWAYS: return 1'b1;
            RDY_RANDOM: return 1'($urandom_range(1, 0));
            RDY_TOGGLE: return cycle[0];
            default:    return ($urandom_range(3, 0) == 0);   // high one cycle in four
        endcase
    endfunction

    task automatic wait_in_ready(input int row);
        int idle;
        idle = 0;
        while (!in_ready) begin
            idle++;
            if (idle > WAIT_LIMIT) report_timeout($sformatf("in_ready before run %0d", row));
            next_cycle();
        end
    endtask

    task automatic load_vector(input int row);
        for (int k = 0; k < N; k++) begin
            in_valid = 1'b1;
            in_data  = stim_coef[row][k];
            check_value(32'(in_ready), 32'd1, "in_ready high through the load");
            next_cycle();   // word k taken at this edge
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_outputs(input int row);
        int                   count;
        int                   idle;
        int                   cycle;
        logic                 stalled;
        ntt_field_pkg::coef_t held_data;
        logic                 held_last;
        count     = 0;
        idle      = 0;
        cycle     = 0;
        stalled   = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        while (count < N) begin
            out_ready = ready_for_mode(run_table[row].ready_mode, cycle);
            if (run_table[row].noise) begin
                in_valid = 1'($urandom_range(1, 0));   // must be ignored while busy
                in_data  = ntt_field_pkg::coef_t'($urandom_range(96, 0));
            end
            check_value(32'(in_ready), 32'd0, "in_ready low while transform busy");
            check_value(32'(out_last), 32'(out_valid && (count == N - 1)),
                        "out_last only with the 16th word");
            if (stalled) begin
                check_value(32'(out_valid), 32'd1, "out_valid held during stall");
                check_value(32'(out_data), 32'(held_data), "out_data held during stall");
                check_value(32'(out_last), 32'(held_last), "out_last held during stall");
            end
            if (out_valid && out_ready) begin
                check_value(32'(out_data), 32'(exp_coef[row][count]),
                            $sformatf("run %0d word %0d against model", row, count));
                count++;
                idle    = 0;
                stalled = 1'b0;
            end else begin
                stalled   = out_valid;   // valid but not taken
                held_data = out_data;
                held_last = out_last;
                idle++;
                if (idle > WAIT_LIMIT) begin
                    report_timeout($sformatf("output word %0d of run %0d", count, row));
                end
            end
            cycle++;
            next_cycle();
        end
        in_valid  = 1'b0;   // gone before in_ready rises
        out_ready = 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        void'($urandom(95859));
        fill_tables();
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        check_value(32'(in_ready), 32'd1, "in_ready after reset");
        check_value(32'(out_valid), 32'd0, "out_valid after reset");
        check_value(32'(out_last), 32'd0, "out_last after reset");
        next_cycle();
        for (int row = 0; row < NUM_RUNS; row++) begin
            wait_in_ready(row);
            repeat (run_table[row].gap) next_cycle();   // gap 0 loads at once
            load_vector(row);
            collect_outputs(row);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/ntt_field_pkg.sv
logic/ntt_ctrl_pkg.sv
logic/ntt_phase_fsm.sv
logic/butterfly_sequencer.sv
logic/coef_memory.sv
logic/twiddle_rom.sv
logic/butterfly_unit.sv
logic/result_streamer.sv
logic/ntt_core.sv
verification/ntt_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ntt_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	@out="$$(./$(BUILD_DIR)/$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
